//--- verilog/adc_if_params.svh
`ifndef ADC_IF_PARAMS_SVH
`define ADC_IF_PARAMS_SVH

// Lane geometry
`define ADC_NUM_LANES 4
`define ADC_SAMPLE_W 10

// Bit pairs per sample, two bits arrive each clock
`define ADC_FRAME_CYC 5

// Expected frame lane word, MSB first on the wire
`define ADC_FRAME_PATTERN 10'b11111_00000

// Register byte offsets
`define ADC_REG_CTRL 32'h0000_0000
`define ADC_REG_SLIP 32'h0000_0004
`define ADC_REG_FRAMES 32'h0000_0008
`define ADC_REG_FERRS 32'h0000_000C
`define ADC_REG_STATUS 32'h0000_0010

`endif

//--- verilog/adc_reg_pkg.sv
package adc_reg_pkg;

  // Wishbone bus address
  typedef logic [31:0] wb_addr_t;

  // Wishbone bus data word
  typedef logic [31:0] wb_data_t;

  // Frame and frame error counters
  typedef logic [31:0] count_t;

  // Slave response state
  // ACK lasts one cycle and covers both ack and err
  typedef enum logic {
    IDLE,
    ACK
  } wb_state_t;

endpackage

//--- verilog/adc_lane_pkg.sv
`include "adc_if_params.svh"

package adc_lane_pkg;

  // One deserialized ADC sample
  typedef logic [`ADC_SAMPLE_W-1:0] sample_t;

  // Bitslip offset, 0 up to sample width minus one
  typedef logic [3:0] slip_t;

  // Output gate
  // ARMED after a rising sync edge, back to DISARMED on soft clear
  typedef enum logic {
    DISARMED,
    ARMED
  } sync_state_t;

endpackage

//--- verilog/adc_wb_regs.sv
`timescale 1ns/1ps

`include "adc_if_params.svh"

module adc_wb_regs (
  input  logic                   fclk_ctr_clk,
  input  logic                   rst,
  input  logic                   wb_cyc_i,
  input  logic                   wb_stb_i,
  input  logic                   wb_we_i,
  input  adc_reg_pkg::wb_addr_t  wb_adr_i,
  input  logic [3:0]             wb_sel_i,
  input  adc_reg_pkg::wb_data_t  wb_dat_i,
  output adc_reg_pkg::wb_data_t  wb_dat_o,
  output logic                   wb_ack_o,
  output logic                   wb_err_o,
  input  adc_reg_pkg::count_t    frame_cnt_i,
  input  adc_reg_pkg::count_t    frame_err_cnt_i,
  input  logic                   armed_i,
  output adc_lane_pkg::slip_t    slip_o [`ADC_NUM_LANES+1],
  output logic                   soft_clr_o
);
  import adc_reg_pkg::*;
  import adc_lane_pkg::*;

  localparam int NUM_SLIP = `ADC_NUM_LANES + 1;
  localparam slip_t SLIP_MAX = slip_t'(`ADC_SAMPLE_W - 1);

  wb_state_t state;
  logic      req;
  logic      addr_ok;
  logic      wr_ok;
  logic      bus_err;
  wb_data_t  rd_data;
  wb_data_t  slip_word;

  function automatic slip_t sat_slip(input logic [3:0] val);
    return (val > SLIP_MAX) ? SLIP_MAX : slip_t'(val);
  endfunction

  // New request, only taken in IDLE so each cycle gets one response
  assign req = wb_cyc_i && wb_stb_i && (state == IDLE);
  assign bus_err = !addr_ok || (wb_we_i && !wr_ok);

  // Address decode and read mux
  always_comb begin
    slip_word = '0;
    for (int i = 0; i < NUM_SLIP; i++) begin
      slip_word[4*i +: 4] = slip_o[i];
    end
    addr_ok = 1'b1;
    wr_ok   = 1'b0;
    rd_data = '0;
    case (wb_adr_i)
      `ADC_REG_CTRL: wr_ok = 1'b1;
      `ADC_REG_SLIP: begin
        wr_ok   = 1'b1;
        rd_data = slip_word;
      end
      `ADC_REG_FRAMES: rd_data = frame_cnt_i;
      `ADC_REG_FERRS:  rd_data = frame_err_cnt_i;
      `ADC_REG_STATUS: rd_data = wb_data_t'(armed_i);
      default: addr_ok = 1'b0;
    endcase
  end

  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      state      <= IDLE;
      wb_ack_o   <= 1'b0;
      wb_err_o   <= 1'b0;
      soft_clr_o <= 1'b0;
      for (int i = 0; i < NUM_SLIP; i++) begin
        slip_o[i] <= '0;
      end
    end else begin
      soft_clr_o <= 1'b0;
      case (state)
        IDLE: begin
          if (req) begin
            state <= ACK;
            if (bus_err) begin
              wb_err_o <= 1'b1;
            end else begin
              wb_ack_o <= 1'b1;
              if (wb_we_i && (wb_adr_i == `ADC_REG_CTRL)) begin
                soft_clr_o <= wb_dat_i[0];
              end
              if (wb_we_i && (wb_adr_i == `ADC_REG_SLIP)) begin
                for (int i = 0; i < NUM_SLIP; i++) begin
                  slip_o[i] <= sat_slip(wb_dat_i[4*i +: 4]);
                end
              end
            end
          end
        end
        ACK: begin
          // Response lasts exactly one cycle
          state    <= IDLE;
          wb_ack_o <= 1'b0;
          wb_err_o <= 1'b0;
        end
        default: state <= IDLE;
      endcase
    end
  end

  // Read data, byte selects play no part since all registers are word wide
  always_ff @(posedge fclk_ctr_clk) begin
    if (req) begin
      wb_dat_o <= rd_data;
    end
  end

  a_ack_err_excl: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    !(wb_ack_o && wb_err_o))
    else $error("wb ack and err high together");

  a_resp_has_req: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    $rose(wb_ack_o || wb_err_o) |-> $past(wb_cyc_i && wb_stb_i))
    else $error("wb response without a request");

endmodule

//--- verilog/adc_lane_deser.sv
`timescale 1ns/1ps

`include "adc_if_params.svh"

module adc_lane_deser (
  input  logic                  fclk_ctr_clk,
  input  logic                  rst,
  input  logic                  rise_i,
  input  logic                  fall_i,
  input  adc_lane_pkg::slip_t   slip_i,
  output adc_lane_pkg::sample_t sample_o,
  output logic                  sample_valid_o
);
  import adc_lane_pkg::*;

  // Two samples of history so any slip up to width minus one finds a whole window
  localparam int HIST_W = 2 * `ADC_SAMPLE_W;
  localparam logic [2:0] LAST_PHASE = 3'(`ADC_FRAME_CYC - 1);

  logic [HIST_W-1:0] hist;
  logic [HIST_W-1:0] hist_nxt;
  logic [2:0]        phase;
  logic              frame_end;
  slip_t             slip_q;

  // Rise bit is older than fall bit, newest bit lands in bit 0
  assign hist_nxt = {hist[HIST_W-3:0], rise_i, fall_i};

  // Fifth bit pair of the frame is being taken this cycle
  assign frame_end = (phase == LAST_PHASE);

  // Phase counter and frame strobe
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      phase          <= '0;
      sample_valid_o <= 1'b0;
    end else begin
      sample_valid_o <= frame_end;
      if (frame_end) begin
        phase <= '0;
      end else begin
        phase <= phase + 3'd1;
      end
    end
  end

  // Slip is only picked up at a frame boundary
  // so a write never tears a sample in progress
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      slip_q <= '0;
    end else if (phase == 3'd0) begin
      slip_q <= slip_i;
    end
  end

  // Bit history keeps shifting through reset
  always_ff @(posedge fclk_ctr_clk) begin
    hist <= hist_nxt;
  end

  // Window that ends slip bits before the newest bit
  always_ff @(posedge fclk_ctr_clk) begin
    if (frame_end) begin
      sample_o <= hist_nxt[slip_q +: `ADC_SAMPLE_W];
    end
  end

  a_valid_period: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    sample_valid_o |=> !sample_valid_o [* (`ADC_FRAME_CYC - 1)] ##1 sample_valid_o)
    else $error("sample_valid_o not once every frame");

endmodule

//--- verilog/adc_frame_gate.sv
`timescale 1ns/1ps

`include "adc_if_params.svh"

module adc_frame_gate (
  input  logic                                     fclk_ctr_clk,
  input  logic                                     rst,
  input  adc_lane_pkg::sample_t                    sample_i [`ADC_NUM_LANES],
  input  adc_lane_pkg::sample_t                    frame_i,
  input  logic                                     sample_valid_i,
  input  logic                                     sync_i,
  input  logic                                     soft_clr_i,
  output adc_reg_pkg::count_t                      frame_cnt_o,
  output adc_reg_pkg::count_t                      frame_err_cnt_o,
  output logic                                     armed_o,
  output logic [`ADC_NUM_LANES*`ADC_SAMPLE_W-1:0]  dout_o,
  output logic                                     dout_valid_o
);
  import adc_reg_pkg::*;
  import adc_lane_pkg::*;

  logic [1:0]  sync_ff;
  logic        sync_prev;
  logic        sync_rise;
  logic        frame_bad;
  logic        primed;
  logic        emit;
  sync_state_t state;

  assign sync_rise = sync_ff[1] & ~sync_prev;
  assign frame_bad = (frame_i != `ADC_FRAME_PATTERN);
  assign armed_o   = (state == ARMED);

  // Output only frames that began after arming
  assign emit = sample_valid_i && armed_o && primed;

  // Sync synchronizer and edge detect
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst) begin
      sync_ff   <= '0;
      sync_prev <= 1'b0;
    end else begin
      sync_ff   <= {sync_ff[0], sync_i};
      sync_prev <= sync_ff[1];
    end
  end

  // Frame and frame error counters
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst || soft_clr_i) begin
      frame_cnt_o     <= '0;
      frame_err_cnt_o <= '0;
    end else if (sample_valid_i) begin
      frame_cnt_o <= frame_cnt_o + 1'b1;
      if (frame_bad) begin
        frame_err_cnt_o <= frame_err_cnt_o + 1'b1;
      end
    end
  end

  // Gate FSM
  // the first frame end after arming only primes the gate,
  // that frame was partly received while disarmed
  always_ff @(posedge fclk_ctr_clk) begin
    if (rst || soft_clr_i) begin
      state        <= DISARMED;
      primed       <= 1'b0;
      dout_valid_o <= 1'b0;
    end else begin
      dout_valid_o <= emit;
      if (state == DISARMED) begin
        if (sync_rise) begin
          state  <= ARMED;
          primed <= 1'b0;
        end
      end else if (sample_valid_i) begin
        primed <= 1'b1;
      end
    end
  end

  // Output stage, lane 0 in the low bits, overwritten by every new frame
  always_ff @(posedge fclk_ctr_clk) begin
    if (emit) begin
      for (int i = 0; i < `ADC_NUM_LANES; i++) begin
        dout_o[i*`ADC_SAMPLE_W +: `ADC_SAMPLE_W] <= sample_i[i];
      end
    end
  end

  a_err_le_frames: assert property (@(posedge fclk_ctr_clk) disable iff (rst)
    frame_err_cnt_o <= frame_cnt_o)
    else $error("frame error count above frame count");

endmodule

//--- verilog/adc_if_top.sv
`timescale 1ns/1ps

`include "adc_if_params.svh"

module adc_if_top (
  input  logic                                     fclk_ctr_clk,
  input  logic                                     rst,
  input  logic                                     sync_i,
  input  logic [`ADC_NUM_LANES-1:0]                din_rise_i,
  input  logic [`ADC_NUM_LANES-1:0]                din_fall_i,
  input  logic                                     fclk_rise_i,
  input  logic                                     fclk_fall_i,
  input  logic                                     wb_cyc_i,
  input  logic                                     wb_stb_i,
  input  logic                                     wb_we_i,
  input  adc_reg_pkg::wb_addr_t                    wb_adr_i,
  input  logic [3:0]                               wb_sel_i,
  input  adc_reg_pkg::wb_data_t                    wb_dat_i,
  output adc_reg_pkg::wb_data_t                    wb_dat_o,
  output logic                                     wb_ack_o,
  output logic                                     wb_err_o,
  output logic [`ADC_NUM_LANES*`ADC_SAMPLE_W-1:0]  dout_o,
  output logic                                     dout_valid_o
);
  import adc_reg_pkg::*;
  import adc_lane_pkg::*;

  slip_t   slip [`ADC_NUM_LANES+1];
  sample_t lane_sample [`ADC_NUM_LANES];
  sample_t frame_sample;
  logic    sample_valid;
  logic    soft_clr;
  logic    armed;
  count_t  frame_cnt;
  count_t  frame_err_cnt;

  adc_wb_regs adc_wb_regs_inst (
    .fclk_ctr_clk    (fclk_ctr_clk),
    .rst             (rst),
    .wb_cyc_i        (wb_cyc_i),
    .wb_stb_i        (wb_stb_i),
    .wb_we_i         (wb_we_i),
    .wb_adr_i        (wb_adr_i),
    .wb_sel_i        (wb_sel_i),
    .wb_dat_i        (wb_dat_i),
    .wb_dat_o        (wb_dat_o),
    .wb_ack_o        (wb_ack_o),
    .wb_err_o        (wb_err_o),
    .frame_cnt_i     (frame_cnt),
    .frame_err_cnt_i (frame_err_cnt),
    .armed_i         (armed),
    .slip_o          (slip),
    .soft_clr_o      (soft_clr)
  );

  // Data lanes, lane 0 provides the shared frame strobe
  for (genvar g = 0; g < `ADC_NUM_LANES; g++) begin : g_data_lane
    if (g == 0) begin : g_ref
      adc_lane_deser adc_lane_deser_inst (
        .fclk_ctr_clk   (fclk_ctr_clk),
        .rst            (rst),
        .rise_i         (din_rise_i[g]),
        .fall_i         (din_fall_i[g]),
        .slip_i         (slip[g]),
        .sample_o       (lane_sample[g]),
        .sample_valid_o (sample_valid)
      );
    end else begin : g_other
      adc_lane_deser adc_lane_deser_inst (
        .fclk_ctr_clk   (fclk_ctr_clk),
        .rst            (rst),
        .rise_i         (din_rise_i[g]),
        .fall_i         (din_fall_i[g]),
        .slip_i         (slip[g]),
        .sample_o       (lane_sample[g]),
        .sample_valid_o ()
      );
    end
  end

  // Frame lane uses the last slip field
  adc_lane_deser adc_frame_deser_inst (
    .fclk_ctr_clk   (fclk_ctr_clk),
    .rst            (rst),
    .rise_i         (fclk_rise_i),
    .fall_i         (fclk_fall_i),
    .slip_i         (slip[`ADC_NUM_LANES]),
    .sample_o       (frame_sample),
    .sample_valid_o ()
  );

  adc_frame_gate adc_frame_gate_inst (
    .fclk_ctr_clk    (fclk_ctr_clk),
    .rst             (rst),
    .sample_i        (lane_sample),
    .frame_i         (frame_sample),
    .sample_valid_i  (sample_valid),
    .sync_i          (sync_i),
    .soft_clr_i      (soft_clr),
    .frame_cnt_o     (frame_cnt),
    .frame_err_cnt_o (frame_err_cnt),
    .armed_o         (armed),
    .dout_o          (dout_o),
    .dout_valid_o    (dout_valid_o)
  );

endmodule

//--- verification/adc_if_tb.sv
`timescale 1ns/1ps

`include "adc_if_params.svh"

module adc_if_tb;

  logic                                    fclk_ctr_clk;
  logic                                    rst;
  logic                                    sync_i;
  logic [`ADC_NUM_LANES-1:0]               din_rise_i;
  logic [`ADC_NUM_LANES-1:0]               din_fall_i;
  logic                                    fclk_rise_i;
  logic                                    fclk_fall_i;
  logic                                    wb_cyc_i;
  logic                                    wb_stb_i;
  logic                                    wb_we_i;
  logic [31:0]                             wb_adr_i;
  logic [3:0]                              wb_sel_i;
  logic [31:0]                             wb_dat_i;
  logic [31:0]                             wb_dat_o;
  logic                                    wb_ack_o;
  logic                                    wb_err_o;
  logic [`ADC_NUM_LANES*`ADC_SAMPLE_W-1:0] dout_o;
  logic                                    dout_valid_o;

  // One entry per bit position with one bit per data lane
  logic [3:0]  bit_q[$];
  logic [39:0] out_q[$];
  string       op_q[$];
  logic [63:0] arg_q[$][4];
  int          bits_sent;
  int          off;
  int          cyc_cnt;
  int          out_pulses;
  int          quiet_mark;
  bit          loaded;

  adc_if_top adc_if_top_inst (
    .fclk_ctr_clk (fclk_ctr_clk),
    .rst          (rst),
    .sync_i       (sync_i),
    .din_rise_i   (din_rise_i),
    .din_fall_i   (din_fall_i),
    .fclk_rise_i  (fclk_rise_i),
    .fclk_fall_i  (fclk_fall_i),
    .wb_cyc_i     (wb_cyc_i),
    .wb_stb_i     (wb_stb_i),
    .wb_we_i      (wb_we_i),
    .wb_adr_i     (wb_adr_i),
    .wb_sel_i     (wb_sel_i),
    .wb_dat_i     (wb_dat_i),
    .wb_dat_o     (wb_dat_o),
    .wb_ack_o     (wb_ack_o),
    .wb_err_o     (wb_err_o),
    .dout_o       (dout_o),
    .dout_valid_o (dout_valid_o)
  );

  initial begin
    fclk_ctr_clk = 1'b0;
    forever #4 fclk_ctr_clk = ~fclk_ctr_clk;
  end

  initial begin
    rst = 1'b1;
    sync_i = 1'b0;
    din_rise_i = '0;
    din_fall_i = '0;
    fclk_rise_i = 1'b0;
    fclk_fall_i = 1'b0;
    wb_cyc_i = 1'b0;
    wb_stb_i = 1'b0;
    wb_we_i = 1'b0;
    wb_adr_i = '0;
    wb_sel_i = '0;
    wb_dat_i = '0;
    bits_sent = 0;
    off = 0;
    cyc_cnt = 0;
    out_pulses = 0;
    quiet_mark = 0;
    loaded = 1'b0;
  end

  task automatic check(input logic [63:0] got, input logic [63:0] exp, input string msg);
    if (got !== exp) begin
      $display("FAILED at time %0t: %s, got %h expected %h", $time, msg, got, exp);
      $display("Simulation finished: FAIL");
      $fatal(1, "check failed");
    end
  endtask

  // Frame lane runs the pattern all the time aligned to the current data offset
  function automatic logic frame_lane_bit(input int pos);
    return ((pos + off) % 10) < 5;
  endfunction

  // Reset sequencing and the serializer with two bits per lane each clock
  always @(posedge fclk_ctr_clk) begin : drive_lanes
    logic [3:0] r;
    logic [3:0] f;
    if (cyc_cnt < 8) begin
      cyc_cnt++;
      rst <= 1'b1;
    end else begin
      r = '0;
      f = '0;
      if (bit_q.size() != 0) begin
        r = bit_q.pop_front();
      end
      if (bit_q.size() != 0) begin
        f = bit_q.pop_front();
      end
      rst <= 1'b0;
      din_rise_i <= r;
      din_fall_i <= f;
      fclk_rise_i <= frame_lane_bit(bits_sent);
      fclk_fall_i <= frame_lane_bit(bits_sent + 1);
      bits_sent += 2;
    end
  end

  // Output monitor
  always @(negedge fclk_ctr_clk) begin
    if (!rst && dout_valid_o === 1'b1) begin
      out_pulses++;
      out_q.push_back(dout_o);
    end
  end

  task automatic wb_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                           output logic [31:0] rdata, output logic ack, output logic err);
    @(posedge fclk_ctr_clk);
    wb_cyc_i <= 1'b1;
    wb_stb_i <= 1'b1;
    wb_we_i  <= we;
    wb_adr_i <= adr;
    wb_dat_i <= dat;
    wb_sel_i <= 4'hf;
    @(negedge fclk_ctr_clk);
    while (!(wb_ack_o || wb_err_o)) begin
      @(negedge fclk_ctr_clk);
    end
    rdata = wb_dat_o;
    ack = wb_ack_o;
    err = wb_err_o;
    @(posedge fclk_ctr_clk);
    wb_cyc_i <= 1'b0;
    wb_stb_i <= 1'b0;
    wb_we_i  <= 1'b0;
    // The response lasts a single cycle
    @(negedge fclk_ctr_clk);
    check(wb_ack_o || wb_err_o, 1'b0, "wb response longer than one cycle");
  endtask

  task automatic drain_lanes();
    while (bit_q.size() != 0) begin
      @(posedge fclk_ctr_clk);
    end
  endtask

  task automatic run_line(input string op, input logic [63:0] a, input logic [63:0] b,
                          input logic [63:0] c, input logic [63:0] d);
    logic [31:0] rdata;
    logic        ack;
    logic        err;
    logic [39:0] word;
    case (op)
      "W": begin
        wb_access(1'b1, a[31:0], b[31:0], rdata, ack, err);
        check(ack, !c[0], $sformatf("ack flag of write to %h", a[31:0]));
        check(err, c, $sformatf("err flag of write to %h", a[31:0]));
        if (a[31:0] == `ADC_REG_CTRL && b[0] && !err) begin
          repeat (3) @(posedge fclk_ctr_clk);
          quiet_mark = out_pulses;
        end
      end
      "R", "G", "L": begin
        wb_access(1'b0, a[31:0], 32'h0, rdata, ack, err);
        check(ack, !c[0], $sformatf("ack flag of read from %h", a[31:0]));
        if (op == "R") begin
          check(err, c, $sformatf("err flag of read from %h", a[31:0]));
          if (!err) begin
            check(rdata, b, $sformatf("read of offset %h", a[31:0]));
          end
        end else if (op == "G") begin
          check(rdata >= b[31:0], 1, $sformatf("offset %h at least %0d", a[31:0], b));
        end else begin
          check(rdata <= b[31:0], 1, $sformatf("offset %h at most %0d", a[31:0], b));
        end
      end
      "Y": begin
        drain_lanes();
        repeat (10) @(posedge fclk_ctr_clk);
        check(out_pulses, quiet_mark, "output pulses while disarmed");
        @(posedge fclk_ctr_clk);
        sync_i <= 1'b1;
        repeat (2) @(posedge fclk_ctr_clk);
        sync_i <= 1'b0;
        // Time for the synchronizer, arming and one priming frame
        repeat (12) @(posedge fclk_ctr_clk);
        out_q.delete();
      end
      "D": begin
        drain_lanes();
        off = (off + int'(a)) % 10;
        repeat (10) @(posedge fclk_ctr_clk);
      end
      "F": begin
        // Pad with idle bits up to the next frame start
        while (((bits_sent + bit_q.size() + off) % 10) != 0) begin
          bit_q.push_back(4'b0);
        end
        for (int i = `ADC_SAMPLE_W - 1; i >= 0; i--) begin
          bit_q.push_back({d[i], c[i], b[i], a[i]});
        end
      end
      "E": begin
        // Idle frames come out as all-zero words
        do begin
          while (out_q.size() == 0) begin
            @(negedge fclk_ctr_clk);
          end
          word = out_q.pop_front();
        end while (word == '0);
        check(word, a, "dout_o word");
      end
      default: begin
        $display("Unknown trace command %s", op);
        $display("Simulation finished: FAIL");
        $fatal(1, "bad trace");
      end
    endcase
  endtask

  // Watchdog sized from the trace length
  initial begin
    wait (loaded);
    repeat (20 * op_q.size() + 200) @(posedge fclk_ctr_clk);
    $display("Timeout: the trace did not finish in time, the DUT stopped responding");
    $display("Simulation finished: FAIL");
    $fatal(1, "timeout");
  end

  initial begin : main
    int          fd;
    string       line;
    string       op;
    logic [63:0] v [4];
    fd = $fopen("verification/adc_if_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file");
      $display("Simulation finished: FAIL");
      $fatal(1, "no trace");
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 1 && line[0] != "#") begin
        v = '{default: '0};
        op = "";
        void'($sscanf(line, "%s %h %h %h %h", op, v[0], v[1], v[2], v[3]));
        op_q.push_back(op);
        arg_q.push_back(v);
      end
    end
    $fclose(fd);
    loaded = 1'b1;
    while (rst !== 1'b0) begin
      @(posedge fclk_ctr_clk);
    end
    repeat (2) @(posedge fclk_ctr_clk);
    for (int i = 0; i < op_q.size(); i++) begin
      run_line(op_q[i], arg_q[i][0], arg_q[i][1], arg_q[i][2], arg_q[i][3]);
    end
    $display("Simulation finished: PASS");
    $finish;
  end

endmodule

//--- verification/adc_if_trace.txt
# op arg1 arg2 arg3 arg4, all hex
# W off data [err]  R off exp [err]  G off min  L off max  Y  D n  F s0 s1 s2 s3  E dout
# Register access
R 10 0
R C 0
W 4 FA943
R 4 99943
W 14 1 1
W 8 0 1
R 20 0 1
W 4 0
R 4 0
# Sync gating
F 111 222 333 0
F 3FF 3FF 3FF 3FF
Y
R 10 1
F 1 2 3 4
F 3FF 0 2AA 155
F 123 0 0 0
E 100300801
E 556AA003FF
E 123
# Bitslip
D 5
W 4 55555
R 4 55555
F 0 200 0 0
F 2AA 155 3FF 1
E 80000
E 7FF556AA
# Soft clear
W 0 1
L 8 2
R C 0
R 10 0
F 1 2 3 4
F 123 0 0 0
Y
R 10 1
F 3FF 0 2AA 155
E 556AA003FF
# Frame checking
W 0 1
D 3
W 4 0
R 4 0
F 1 2 3 4
F 123 0 0 0
G C 2
G 8 2
R 10 0

//--- src.f
+incdir+verilog
verilog/adc_reg_pkg.sv
verilog/adc_lane_pkg.sv
verilog/adc_wb_regs.sv
verilog/adc_lane_deser.sv
verilog/adc_frame_gate.sv
verilog/adc_if_top.sv
verification/adc_if_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := adc_if_tb
FILELIST  := src.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation finished: PASS" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
